//--- flist.f
+incdir+design
design/rvfi_pkg.sv
design/rvfi_cfg_regs.sv
design/rvfi_shadow_pipe.sv
design/rvfi_retire.sv
design/rvfi_trace_top.sv
tb/tb_rvfi_trace.sv

//--- tb/tb_rvfi_trace.sv
`default_nettype none

`include "rvfi_macros.svh"

module tb_rvfi_trace import rvfi_pkg::*; ();

    // one instruction of the stimulus model, with every stage event it will see
    typedef struct packed {
        logic       valid;
        // stage whose flush drops it, 0 when it retires
        logic [1:0] kill;
        xlen_t      if_pc;
        id_evt_t    id;
        ex_evt_t    ex;
        mem_evt_t   mem;
        wb_evt_t    wb;
    } instr_t;

    logic                    clk_i;
    logic                    rst_n_i;
    if_evt_t                 if_evt_i;
    id_evt_t                 id_evt_i;
    ex_evt_t                 ex_evt_i;
    mem_evt_t                mem_evt_i;
    wb_evt_t                 wb_evt_i;
    logic                    cfg_we_i;
    logic [`RVFI_CFG_AW-1:0] cfg_addr_i;
    xlen_t                   cfg_wdata_i;
    xlen_t                   cfg_rdata_o;
    rvfi_rec_t               rvfi_o;

    // pipeline model, slots 0 to 3 are ID, EX, MEM, WB
    instr_t     slot [4];
    rvfi_rec_t  exp_q [$];
    rvfi_rec_t  exp_rec;
    logic       exp_valid;
    order_t     exp_order;
    logic       stall_q;
    logic       issue_en;
    logic       stall_en;
    logic       flush_en;
    logic [31:0] lfsr_q;

    // configuration as the model sees it
    xlen_t      misa_m;
    logic [1:0] mode_m;
    logic       trace_en_m;
    logic       cfg_chk;
    xlen_t      cfg_exp;

    int         err_cnt;
    int         err_base;
    int         rec_cnt;
    int         test_cnt;
    string      test_name;

    rvfi_trace_top u_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .if_evt_i    (if_evt_i),
        .id_evt_i    (id_evt_i),
        .ex_evt_i    (ex_evt_i),
        .mem_evt_i   (mem_evt_i),
        .wb_evt_i    (wb_evt_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .rvfi_o      (rvfi_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // random source and error lines
    //////////////////////////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic void value_err(input string name, input logic [63:0] got,
                                      input logic [63:0] exp);
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        err_cnt++;
    endfunction

    function automatic void check_field(input string name, input logic [63:0] got,
                                        input logic [63:0] exp);
        if (got !== exp) begin
            value_err({"rvfi_o.", name}, got, exp);
        end
    endfunction

    // walk the record, one line per wrong field
    function automatic void show_diff(input rvfi_rec_t got, input rvfi_rec_t exp);
        check_field("order", got.order, exp.order);
        check_field("insn", got.insn, exp.insn);
        check_field("trap", got.trap, exp.trap);
        check_field("intr", got.intr, exp.intr);
        check_field("mode", got.mode, exp.mode);
        check_field("ixl", got.ixl, exp.ixl);
        check_field("rs1_addr", got.rs1_addr, exp.rs1_addr);
        check_field("rs1_rdata", got.rs1_rdata, exp.rs1_rdata);
        check_field("rs2_addr", got.rs2_addr, exp.rs2_addr);
        check_field("rs2_rdata", got.rs2_rdata, exp.rs2_rdata);
        check_field("rd_addr", got.rd_addr, exp.rd_addr);
        check_field("rd_wdata", got.rd_wdata, exp.rd_wdata);
        check_field("pc_rdata", got.pc_rdata, exp.pc_rdata);
        check_field("pc_wdata", got.pc_wdata, exp.pc_wdata);
        check_field("mem_addr", got.mem_addr, exp.mem_addr);
        check_field("mem_rmask", got.mem_rmask, exp.mem_rmask);
        check_field("mem_wmask", got.mem_wmask, exp.mem_wmask);
        check_field("mem_rdata", got.mem_rdata, exp.mem_rdata);
        check_field("mem_wdata", got.mem_wdata, exp.mem_wdata);
        check_field("misa_rdata", got.misa_rdata, exp.misa_rdata);
        check_field("misa_wdata", got.misa_wdata, exp.misa_wdata);
        check_field("csr_rmask", got.csr_rmask, exp.csr_rmask);
        check_field("csr_rdata", got.csr_rdata, exp.csr_rdata);
        check_field("csr_wmask", got.csr_wmask, exp.csr_wmask);
        check_field("csr_wdata", got.csr_wdata, exp.csr_wdata);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks, sampled on the rising edge
    //////////////////////////////////////////////////////////////////////

    a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvfi_o.valid == exp_valid)
        else value_err("rvfi_o.valid", $sampled(rvfi_o.valid), $sampled(exp_valid));

    // order moves only with a record and holds otherwise
    a_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvfi_o.order == exp_order)
        else value_err("rvfi_o.order", $sampled(rvfi_o.order), $sampled(exp_order));

    a_record: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exp_valid |-> (rvfi_o == exp_rec))
        else show_diff($sampled(rvfi_o), $sampled(exp_rec));

    a_cfg_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cfg_chk |-> (cfg_rdata_o == cfg_exp))
        else value_err("cfg_rdata_o", $sampled(cfg_rdata_o), $sampled(cfg_exp));

    //////////////////////////////////////////////////////////////////////
    // stimulus model
    //////////////////////////////////////////////////////////////////////

    function automatic instr_t make_instr();
        instr_t t;
        t                 = '0;
        t.valid           = 1'b1;
        t.id.instr        = rand_bits(32);
        t.id.alu_source_1 = alu_source_1_t'(rand_bits(2) % 3);
        t.id.alu_source_2 = alu_source_2_t'(rand_bits(1));
        t.id.rs1_addr     = reg_addr_t'(rand_bits(5));
        t.id.rs2_addr     = reg_addr_t'(rand_bits(5));
        t.id.rs1_data     = rand_bits(32);
        t.id.rs2_data     = rand_bits(32);
        t.id.pc           = rand_bits(32) & ~32'h3;
        t.id.pc_source    = pc_source_t'(rand_bits(2));
        t.id.jump_target  = rand_bits(32);
        t.id.mem_wen      = 1'(rand_bits(1));
        // sequential fetch behind the ID instruction
        t.if_pc           = t.id.pc + 32'd4;
        t.ex.branch_target = rand_bits(32);
        t.ex.branch_taken = (t.id.pc_source == PC_BRANCH) && rand_bits(1) != 0;
        t.ex.csr_wdata    = rand_bits(32);
        t.ex.csr_rdata    = rand_bits(32);
        t.mem.dmem_addr   = rand_bits(32);
        t.mem.dmem_wdata  = rand_bits(32);
        t.mem.dmem_wen    = t.id.mem_wen;
        t.mem.dmem_ben    = ben_t'(rand_bits(4));
        // x0 about one time in four
        t.wb.rd_addr      = (rand_bits(2) == 0) ? '0 : reg_addr_t'(rand_bits(5));
        t.wb.reg_wen      = 1'(rand_bits(1));
        t.wb.reg_wdata    = rand_bits(32);
        t.wb.mem_rdata    = rand_bits(32);
        if (flush_en && rand_bits(2) == 0) begin
            t.kill = 2'(rand_bits(2) % 3 + 1);
        end
        return t;
    endfunction

    // record fields fixed at issue, order and config are added in WB
    function automatic rvfi_rec_t expected_of(input instr_t t);
        rvfi_rec_t e;
        logic      use1;
        logic      use2;
        e    = '0;
        use1 = (t.id.alu_source_1 == ALU_SRC1_RS1) || (t.id.pc_source == PC_JALR);
        use2 = (t.id.alu_source_2 == ALU_SRC2_RS2) || t.id.mem_wen;
        e.insn = t.id.instr;
        if (use1) begin
            e.rs1_addr  = t.id.rs1_addr;
            e.rs1_rdata = t.id.rs1_data;
        end
        if (use2) begin
            e.rs2_addr  = t.id.rs2_addr;
            e.rs2_rdata = t.id.rs2_data;
        end
        e.rd_addr  = t.wb.reg_wen ? t.wb.rd_addr : '0;
        e.rd_wdata = (e.rd_addr == '0) ? '0 : t.wb.reg_wdata;
        e.pc_rdata = t.id.pc;
        if (t.ex.branch_taken) begin
            e.pc_wdata = t.ex.branch_target;
        end else if (t.id.pc_source == PC_JAL || t.id.pc_source == PC_JALR) begin
            e.pc_wdata = t.id.jump_target;
        end else begin
            e.pc_wdata = t.if_pc;
        end
        e.mem_addr   = t.mem.dmem_addr;
        e.mem_rmask  = t.mem.dmem_ben;
        e.mem_wmask  = t.mem.dmem_wen ? t.mem.dmem_ben : '0;
        e.mem_rdata  = t.wb.mem_rdata;
        e.mem_wdata  = t.mem.dmem_wdata;
        e.misa_wdata = t.ex.csr_wdata;
        e.csr_rmask  = '1;
        e.csr_rdata  = t.ex.csr_rdata;
        e.csr_wmask  = '1;
        e.csr_wdata  = t.ex.csr_wdata;
        return e;
    endfunction

    // one model cycle, called right after a falling edge
    task automatic step();
        logic stall;
        // a record at the last rising edge moved the counter on
        if (exp_valid) begin
            exp_order = exp_order + 1;
            rec_cnt++;
        end
        if (stall_q) begin
            slot[3] = '0;
        end else begin
            slot[3] = (slot[2].kill == 2'd3) ? '0 : slot[2];
            slot[2] = (slot[1].kill == 2'd2) ? '0 : slot[1];
            slot[1] = (slot[0].kill == 2'd1) ? '0 : slot[0];
            slot[0] = '0;
        end
        if (!slot[0].valid && issue_en && rand_bits(2) != 0) begin
            slot[0] = make_instr();
            if (slot[0].kill == 2'd0) begin
                exp_q.push_back(expected_of(slot[0]));
            end
        end
        stall   = stall_en && (rand_bits(3) == 0);
        stall_q = stall;

        if_evt_i       = '0;
        if_evt_i.valid = slot[0].valid;
        if_evt_i.stall = stall;
        if_evt_i.pc    = slot[0].if_pc;
        id_evt_i       = slot[0].id;
        id_evt_i.valid = slot[0].valid;
        id_evt_i.stall = stall;
        // each flush drops the entry moving into that stage
        ex_evt_i        = slot[1].ex;
        ex_evt_i.valid  = slot[1].valid;
        ex_evt_i.stall  = stall;
        ex_evt_i.flush  = !stall && slot[0].kill == 2'd1;
        mem_evt_i       = slot[2].mem;
        mem_evt_i.valid = slot[2].valid;
        mem_evt_i.stall = stall;
        mem_evt_i.flush = !stall && slot[1].kill == 2'd2;
        wb_evt_i        = slot[3].wb;
        wb_evt_i.flush  = !stall && slot[2].kill == 2'd3;

        exp_valid = 1'b0;
        if (slot[3].valid) begin
            if (exp_q.size() == 0) begin
                $display("instruction reached WB with no expected record queued");
                err_cnt++;
            end else begin
                exp_rec            = exp_q.pop_front();
                exp_rec.valid      = 1'b1;
                exp_rec.order      = exp_order;
                exp_rec.mode       = mode_m;
                exp_rec.ixl        = misa_m[31:30];
                exp_rec.misa_rdata = misa_m;
                exp_valid          = trace_en_m;
            end
        end
    endtask

    task automatic tick();
        @(negedge clk_i);
        step();
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequencing
    //////////////////////////////////////////////////////////////////////

    task automatic cfg_write(input logic [`RVFI_CFG_AW-1:0] addr, input xlen_t data);
        tick();
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge clk_i);
        cfg_we_i = 1'b0;
        case (addr)
            `RVFI_CFG_MISA: misa_m = data;
            `RVFI_CFG_MODE: mode_m = data[1:0];
            `RVFI_CFG_CTRL: trace_en_m = data[0];
            default: ;
        endcase
        step();
    endtask

    task automatic cfg_read_check(input logic [`RVFI_CFG_AW-1:0] addr, input xlen_t val);
        tick();
        cfg_addr_i = addr;
        cfg_exp    = val;
        cfg_chk    = 1'b1;
        tick();
        cfg_chk = 1'b0;
    endtask

    // stop issuing and wait for the model pipe to empty
    task automatic drain();
        int n;
        issue_en = 1'b0;
        n        = 0;
        while ((slot[0].valid || slot[1].valid || slot[2].valid || slot[3].valid)
               && n < 64) begin
            tick();
            n++;
        end
        if (slot[0].valid || slot[1].valid || slot[2].valid || slot[3].valid) begin
            $display("timeout while waiting for the pipeline to drain");
            $display("TB FAILED");
            $finish;
        end
        tick();
        tick();
        if (exp_q.size() != 0) begin
            $display("%0d expected records were never retired", exp_q.size());
            err_cnt++;
        end
    endtask

    task automatic test_begin(input string name);
        test_cnt++;
        test_name = name;
        err_base  = err_cnt;
    endtask

    task automatic test_end();
        $display("test %0d %s: %s", test_cnt, test_name,
                 (err_cnt == err_base) ? "ok" : "mismatches");
    endtask

    initial begin
        rst_n_i     = 1'b0;
        if_evt_i    = '0;
        id_evt_i    = '0;
        ex_evt_i    = '0;
        mem_evt_i   = '0;
        wb_evt_i    = '0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        slot        = '{default: '0};
        exp_rec     = '0;
        exp_valid   = 1'b0;
        exp_order   = '0;
        stall_q     = 1'b0;
        issue_en    = 1'b0;
        stall_en    = 1'b0;
        flush_en    = 1'b0;
        lfsr_q      = 32'h202e71f0;
        misa_m      = 32'h4000_0100;
        mode_m      = 2'b11;
        trace_en_m  = 1'b1;
        cfg_chk     = 1'b0;
        cfg_exp     = '0;
        err_cnt     = 0;
        rec_cnt     = 0;
        test_cnt    = 0;
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;

        test_begin("reset state");
        repeat (4) tick();
        cfg_read_check(`RVFI_CFG_MISA, 32'h4000_0100);
        cfg_read_check(`RVFI_CFG_MODE, 32'd3);
        cfg_read_check(`RVFI_CFG_CTRL, 32'd1);
        test_end();

        test_begin("no stalls, fixed latency");
        issue_en = 1'b1;
        repeat (40) tick();
        drain();
        test_end();

        test_begin("operand masking under stalls");
        stall_en = 1'b1;
        issue_en = 1'b1;
        repeat (80) tick();
        drain();
        test_end();

        test_begin("flushed instructions");
        flush_en = 1'b1;
        issue_en = 1'b1;
        repeat (80) tick();
        drain();
        test_end();

        test_begin("trace enable and config");
        flush_en = 1'b0;
        stall_en = 1'b0;
        cfg_write(`RVFI_CFG_CTRL, 32'd0);
        issue_en = 1'b1;
        repeat (20) tick();
        drain();
        cfg_write(`RVFI_CFG_CTRL, 32'd1);
        // rv64 style mxl so ixl changes
        cfg_write(`RVFI_CFG_MISA, 32'h8000_1104);
        cfg_write(`RVFI_CFG_MODE, 32'd0);
        cfg_read_check(`RVFI_CFG_MISA, 32'h8000_1104);
        cfg_read_check(`RVFI_CFG_MODE, 32'd0);
        issue_en = 1'b1;
        repeat (20) tick();
        drain();
        test_end();

        $display("tests %0d, records %0d, errors %0d", test_cnt, rec_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/rvfi_trace_top.sv
`default_nettype none

`include "rvfi_macros.svh"

module rvfi_trace_top import rvfi_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    // per-stage events, as levels
    input  wire if_evt_t                if_evt_i,
    input  wire id_evt_t                id_evt_i,
    input  wire ex_evt_t                ex_evt_i,
    input  wire mem_evt_t               mem_evt_i,
    input  wire wb_evt_t                wb_evt_i,
    // configuration port
    input  wire logic                   cfg_we_i,
    input  wire logic [`RVFI_CFG_AW-1:0] cfg_addr_i,
    input  wire xlen_t                  cfg_wdata_i,
    output xlen_t                       cfg_rdata_o,
    // retirement record
    output rvfi_rec_t                   rvfi_o
);

    cfg_t       cfg;
    stage_rec_t mem_rec;
    logic       mem_valid;

    rvfi_cfg_regs u_cfg_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg_o       (cfg)
    );

    // IF through MEM shadow registers
    rvfi_shadow_pipe u_shadow_pipe (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .if_evt_i    (if_evt_i),
        .id_evt_i    (id_evt_i),
        .ex_evt_i    (ex_evt_i),
        .mem_evt_i   (mem_evt_i),
        .mem_rec_o   (mem_rec),
        .mem_valid_o (mem_valid)
    );

    // WB entry and record output
    rvfi_retire u_retire (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mem_rec_i   (mem_rec),
        .mem_valid_i (mem_valid),
        .mem_evt_i   (mem_evt_i),
        .wb_evt_i    (wb_evt_i),
        .cfg_i       (cfg),
        .rvfi_o      (rvfi_o)
    );

endmodule

`default_nettype wire

//--- design/rvfi_retire.sv
`default_nettype none

`include "rvfi_macros.svh"

module rvfi_retire import rvfi_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire stage_rec_t mem_rec_i,
    input  wire logic       mem_valid_i,
    input  wire mem_evt_t   mem_evt_i,
    input  wire wb_evt_t    wb_evt_i,
    input  wire cfg_t       cfg_i,
    output rvfi_rec_t       rvfi_o
);

    // WB shadow entry
    stage_rec_t wb_q;
    logic       valid_wb_q;

    // memory access seen at the MEM to WB edge
    xlen_t      mem_addr_q;
    xlen_t      mem_wdata_q;
    ben_t       mem_rmask_q;
    ben_t       mem_wmask_q;

    order_t     order_q;
    logic       emit;
    reg_addr_t  rd_addr;

    //////////////////////////////////////////////////////////////////////
    // MEM to WB, never stalls
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_wb_q <= 1'b0;
            wb_q       <= '0;
        end else if (wb_evt_i.flush) begin
            // bubble, trap and intr survive
            valid_wb_q <= 1'b0;
            wb_q       <= '0;
            wb_q.trap  <= mem_rec_i.trap;
            wb_q.intr  <= mem_rec_i.intr;
        end else begin
            valid_wb_q <= mem_valid_i;
            wb_q       <= mem_rec_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_addr_q  <= '0;
            mem_wdata_q <= '0;
            mem_rmask_q <= '0;
            mem_wmask_q <= '0;
        end else if (wb_evt_i.flush) begin
            mem_addr_q  <= '0;
            mem_wdata_q <= '0;
            mem_rmask_q <= '0;
            mem_wmask_q <= '0;
        end else begin
            mem_addr_q  <= mem_evt_i.dmem_addr;
            mem_wdata_q <= mem_evt_i.dmem_wdata;
            mem_rmask_q <= mem_evt_i.dmem_ben;
            // loads leave the write mask empty
            mem_wmask_q <= mem_evt_i.dmem_wen ? mem_evt_i.dmem_ben : '0;
        end
    end

    // one step per emitted record
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            order_q <= '0;
        end else begin
            order_q <= order_q + order_t'(emit);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // record assembly
    //////////////////////////////////////////////////////////////////////

    assign emit    = (valid_wb_q || wb_q.trap) && cfg_i.trace_en;
    // no write means no destination
    assign rd_addr = wb_evt_i.reg_wen ? wb_evt_i.rd_addr : '0;

    always_comb begin
        rvfi_o       = '0;
        rvfi_o.valid = emit;
        rvfi_o.order = order_q;
        rvfi_o.insn  = wb_q.instr;
        rvfi_o.trap  = wb_q.trap;
        rvfi_o.intr  = wb_q.intr;
        rvfi_o.mode  = cfg_i.mode;
        // mxl field of misa
        rvfi_o.ixl   = cfg_i.misa[`RVFI_XLEN-1 -: 2];

        rvfi_o.rs1_addr  = wb_q.rs1_addr;
        rvfi_o.rs1_rdata = wb_q.rs1_rdata;
        rvfi_o.rs2_addr  = wb_q.rs2_addr;
        rvfi_o.rs2_rdata = wb_q.rs2_rdata;
        rvfi_o.rd_addr   = rd_addr;
        // x0 always reads back zero
        rvfi_o.rd_wdata  = (rd_addr == '0) ? '0 : wb_evt_i.reg_wdata;

        rvfi_o.pc_rdata = wb_q.pc;
        rvfi_o.pc_wdata = wb_q.pc_next;

        rvfi_o.mem_addr  = mem_addr_q;
        rvfi_o.mem_rmask = mem_rmask_q;
        rvfi_o.mem_wmask = mem_wmask_q;
        rvfi_o.mem_rdata = wb_evt_i.mem_rdata;
        rvfi_o.mem_wdata = mem_wdata_q;

        // one csr pair stands for all csrs
        rvfi_o.misa_rdata = cfg_i.misa;
        rvfi_o.misa_wdata = wb_q.csr_wdata;
        rvfi_o.csr_rmask  = {`RVFI_XLEN{valid_wb_q}};
        rvfi_o.csr_rdata  = wb_q.csr_rdata;
        rvfi_o.csr_wmask  = {`RVFI_XLEN{valid_wb_q}};
        rvfi_o.csr_wdata  = wb_q.csr_wdata;
    end

    a_order_step: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (order_q == $past(order_q)) || (order_q == $past(order_q) + 1'b1)
    );

    a_rd_x0_zero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rvfi_o.valid && (rvfi_o.rd_addr == '0) |-> (rvfi_o.rd_wdata == '0)
    );

endmodule

`default_nettype wire

//--- design/rvfi_shadow_pipe.sv
`default_nettype none

module rvfi_shadow_pipe import rvfi_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire if_evt_t  if_evt_i,
    input  wire id_evt_t  id_evt_i,
    input  wire ex_evt_t  ex_evt_i,
    input  wire mem_evt_t mem_evt_i,
    output stage_rec_t    mem_rec_o,
    output logic          mem_valid_o
);

    // interrupt flag following the fetch
    logic       intr_if_q;
    logic       intr_id_q;

    // shadow entries
    stage_rec_t ex_d;
    stage_rec_t ex_q;
    stage_rec_t mem_d;
    stage_rec_t mem_q;
    logic       ex_valid_q;
    logic       mem_valid_q;

    // operand use in ID
    logic       use_rs1;
    logic       use_rs2;

    // flushed slot, keeps only trap and intr
    function automatic stage_rec_t bubble(input stage_rec_t rec);
        stage_rec_t b;
        b      = '0;
        b.trap = rec.trap;
        b.intr = rec.intr;
        return b;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // IF and ID
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            intr_if_q <= 1'b0;
            intr_id_q <= 1'b0;
        end else begin
            // fetch redirected to the trap vector
            if (!if_evt_i.stall) begin
                intr_if_q <= if_evt_i.valid && (if_evt_i.next_pc_mux == NPC_EXCEPTION);
            end
            // ID drops the flag on a flush
            if (!id_evt_i.stall) begin
                intr_id_q <= id_evt_i.flush ? 1'b0 : intr_if_q;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ID to EX
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        use_rs1 = (id_evt_i.alu_source_1 == ALU_SRC1_RS1) || (id_evt_i.pc_source == PC_JALR);
        use_rs2 = (id_evt_i.alu_source_2 == ALU_SRC2_RS2) || id_evt_i.mem_wen;

        ex_d       = '0;
        ex_d.instr = id_evt_i.instr;
        // a taken branch kills the ID trap
        ex_d.trap  = id_evt_i.trap && !id_evt_i.stall && !ex_evt_i.branch_taken;
        ex_d.intr  = intr_id_q;
        ex_d.pc    = id_evt_i.pc;

        // operands not read by the instruction are reported as x0
        if (use_rs1) begin
            ex_d.rs1_addr  = id_evt_i.rs1_addr;
            ex_d.rs1_rdata = id_evt_i.rs1_data;
        end
        if (use_rs2) begin
            ex_d.rs2_addr  = id_evt_i.rs2_addr;
            ex_d.rs2_rdata = id_evt_i.rs2_data;
        end

        // jumps resolve in ID, else the fetch pc is next
        if (id_evt_i.pc_source inside {PC_JAL, PC_JALR}) begin
            ex_d.pc_next = id_evt_i.jump_target;
        end else begin
            ex_d.pc_next = if_evt_i.pc;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_q       <= '0;
            ex_valid_q <= 1'b0;
        end else if (!ex_evt_i.stall) begin
            ex_q       <= ex_evt_i.flush ? bubble(ex_d) : ex_d;
            ex_valid_q <= !ex_evt_i.flush && id_evt_i.valid && !id_evt_i.stall;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // EX to MEM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_d      = ex_q;
        mem_d.trap = ex_q.trap || (ex_evt_i.trap && !ex_evt_i.stall);
        // branches resolve in EX
        if (ex_evt_i.branch_taken) begin
            mem_d.pc_next = ex_evt_i.branch_target;
        end
        mem_d.csr_wdata = ex_evt_i.csr_wdata;
        mem_d.csr_rdata = ex_evt_i.csr_rdata;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_q       <= '0;
            mem_valid_q <= 1'b0;
        end else if (!mem_evt_i.stall) begin
            mem_q       <= mem_evt_i.flush ? bubble(mem_d) : mem_d;
            mem_valid_q <= !mem_evt_i.flush && ex_valid_q && ex_evt_i.valid && !ex_evt_i.stall;
        end
    end

    // entry only counts in the cycle it leaves MEM
    always_comb begin
        mem_rec_o      = mem_q;
        mem_rec_o.trap = mem_q.trap && !mem_evt_i.stall;
    end

    assign mem_valid_o = mem_valid_q && mem_evt_i.valid && !mem_evt_i.stall;

    // a flushed MEM slot carries no rs1 operand
    a_flush_clears_rs1: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_evt_i.flush && !mem_evt_i.stall |=>
            (mem_q.rs1_addr == '0) && (mem_q.rs1_rdata == '0)
    );

endmodule

`default_nettype wire

//--- design/rvfi_cfg_regs.sv
`default_nettype none

`include "rvfi_macros.svh"

module rvfi_cfg_regs import rvfi_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   cfg_we_i,
    input  wire logic [`RVFI_CFG_AW-1:0] cfg_addr_i,
    input  wire xlen_t                  cfg_wdata_i,
    output xlen_t                       cfg_rdata_o,
    output cfg_t                        cfg_o
);

    cfg_t cfg_q;

    // write side, one register per strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q.misa     <= `RVFI_MISA_RST;
            cfg_q.mode     <= `RVFI_MODE_RST;
            cfg_q.trace_en <= 1'b1;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                `RVFI_CFG_MISA: cfg_q.misa     <= cfg_wdata_i;
                `RVFI_CFG_MODE: cfg_q.mode     <= cfg_wdata_i[1:0];
                `RVFI_CFG_CTRL: cfg_q.trace_en <= cfg_wdata_i[0];
                // unmapped, dropped
                default: ;
            endcase
        end
    end

    // read mux, zero extended
    always_comb begin
        case (cfg_addr_i)
            `RVFI_CFG_MISA: cfg_rdata_o = cfg_q.misa;
            `RVFI_CFG_MODE: cfg_rdata_o = {{(`RVFI_XLEN-2){1'b0}}, cfg_q.mode};
            `RVFI_CFG_CTRL: cfg_rdata_o = {{(`RVFI_XLEN-1){1'b0}}, cfg_q.trace_en};
            default:        cfg_rdata_o = '0;
        endcase
    end

    assign cfg_o = cfg_q;

    // host side must hold off until reset is released
    a_no_write_in_reset: assert property (
        @(posedge clk_i) !rst_n_i |-> !cfg_we_i
    );

endmodule

`default_nettype wire

//--- design/rvfi_pkg.sv
`default_nettype none

`include "rvfi_macros.svh"

package rvfi_pkg;

    // widths with a meaning
    typedef logic [`RVFI_XLEN-1:0]    xlen_t;
    typedef logic [`RVFI_REG_AW-1:0]  reg_addr_t;
    typedef logic [`RVFI_BEN_W-1:0]   ben_t;
    typedef logic [`RVFI_ORDER_W-1:0] order_t;

    // selects as the core encodes them
    typedef enum logic [1:0] {
        NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_EXCEPTION
    } next_pc_mux_t;
    typedef enum logic [1:0] {
        ALU_SRC1_RS1, ALU_SRC1_PC, ALU_SRC1_ZERO
    } alu_source_1_t;
    typedef enum logic {
        ALU_SRC2_RS2, ALU_SRC2_IMM
    } alu_source_2_t;
    typedef enum logic [1:0] {
        PC_SEQ, PC_JAL, PC_JALR, PC_BRANCH
    } pc_source_t;

    //////////////////////////////////////////////////////////////////////
    // per-stage events from the core
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic         valid;
        logic         stall;
        xlen_t        pc;
        next_pc_mux_t next_pc_mux;
    } if_evt_t;

    typedef struct packed {
        logic          valid;
        logic          stall;
        logic          flush;
        logic          trap;
        xlen_t         instr;
        logic          illegal;
        alu_source_1_t alu_source_1;
        alu_source_2_t alu_source_2;
        reg_addr_t     rs1_addr;
        reg_addr_t     rs2_addr;
        // forwarded operand values
        xlen_t         rs1_data;
        xlen_t         rs2_data;
        xlen_t         pc;
        pc_source_t    pc_source;
        xlen_t         jump_target;
        logic          mem_wen;
    } id_evt_t;

    typedef struct packed {
        logic  valid;
        logic  stall;
        logic  flush;
        logic  trap;
        xlen_t branch_target;
        logic  branch_taken;
        xlen_t csr_wdata;
        xlen_t csr_rdata;
    } ex_evt_t;

    typedef struct packed {
        logic  valid;
        logic  stall;
        logic  flush;
        xlen_t dmem_addr;
        xlen_t dmem_wdata;
        logic  dmem_wen;
        ben_t  dmem_ben;
    } mem_evt_t;

    typedef struct packed {
        logic      flush;
        reg_addr_t rd_addr;
        logic      reg_wen;
        xlen_t     reg_wdata;
        xlen_t     mem_rdata;
    } wb_evt_t;

    //////////////////////////////////////////////////////////////////////
    // shadow entry, output record, configuration
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        xlen_t     instr;
        logic      trap;
        logic      intr;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        xlen_t     rs1_rdata;
        xlen_t     rs2_rdata;
        xlen_t     pc;
        xlen_t     pc_next;
        xlen_t     csr_wdata;
        xlen_t     csr_rdata;
    } stage_rec_t;

    typedef struct packed {
        logic       valid;
        order_t     order;
        xlen_t      insn;
        logic       trap;
        logic       intr;
        logic [1:0] mode;
        logic [1:0] ixl;
        reg_addr_t  rs1_addr;
        xlen_t      rs1_rdata;
        reg_addr_t  rs2_addr;
        xlen_t      rs2_rdata;
        reg_addr_t  rd_addr;
        xlen_t      rd_wdata;
        xlen_t      pc_rdata;
        xlen_t      pc_wdata;
        xlen_t      mem_addr;
        ben_t       mem_rmask;
        ben_t       mem_wmask;
        xlen_t      mem_rdata;
        xlen_t      mem_wdata;
        xlen_t      misa_rdata;
        xlen_t      misa_wdata;
        xlen_t      csr_rmask;
        xlen_t      csr_rdata;
        xlen_t      csr_wmask;
        xlen_t      csr_wdata;
    } rvfi_rec_t;

    typedef struct packed {
        xlen_t      misa;
        logic [1:0] mode;
        logic       trace_en;
    } cfg_t;

endpackage

`default_nettype wire

//--- design/rvfi_macros.svh
`ifndef RVFI_MACROS_SVH
`define RVFI_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// data word and pc
`define RVFI_XLEN    32
// integer register index
`define RVFI_REG_AW  5
// one bit per data byte
`define RVFI_BEN_W   4
// retirement counter
`define RVFI_ORDER_W 64

//////////////////////////////////////////////////////////////////////
// configuration register map
//////////////////////////////////////////////////////////////////////

`define RVFI_CFG_AW   2
`define RVFI_CFG_MISA 2'd0
`define RVFI_CFG_MODE 2'd1
`define RVFI_CFG_CTRL 2'd2

// reset values, rv32i in machine mode
`define RVFI_MISA_RST 32'h4000_0100
`define RVFI_MODE_RST 2'b11

`endif
